//--- src/fxp_pkg.sv
package fxp_pkg;

    // Q8.7 operands and results
    localparam int DATA_W    = 16;
    localparam int FRAC_BITS = 7;
    localparam int PROD_W    = 2 * DATA_W;

    typedef enum logic [1:0] {
        OP_MUL  = 2'd0,
        OP_SQR  = 2'd1,
        OP_NMUL = 2'd2
    } op_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } mul_state_t;

    typedef struct packed {
        op_t               opcode;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } op_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] multiplicand;
        logic [DATA_W-1:0] multiplier;
    } mul_pair_t;

    typedef struct packed {
        logic [DATA_W-1:0] product;
        logic              overflow;
    } mul_result_t;

endpackage

//--- src/op_decode.sv
module op_decode import fxp_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  op_req_t   req,
    output logic      pair_valid,
    output mul_pair_t pair
);

    mul_pair_t pair_next;

    // Operand pair by opcode
    always_comb begin
        case (req.opcode)
            OP_SQR: begin
                pair_next.multiplicand = req.a;
                pair_next.multiplier   = req.a;
            end
            OP_NMUL: begin
                // Wraps for the most negative value
                pair_next.multiplicand = -req.a;
                pair_next.multiplier   = req.b;
            end
            default: begin
                pair_next.multiplicand = req.a;
                pair_next.multiplier   = req.b;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            pair <= pair_next;
        end
    end

    // Source must only send known opcodes
    a_opcode_known: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> (req.opcode inside {OP_MUL, OP_SQR, OP_NMUL})
    ) else $error("op_decode: undefined opcode %0d", req.opcode);

endmodule

//--- src/operand_fifo.sv
module operand_fifo import fxp_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  mul_pair_t push_pair,
    input  logic      pop,
    output mul_pair_t head,
    output logic      empty,
    output logic      almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mul_pair_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pair;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Show-ahead head entry
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

    // Leaves room for one request still in the decoder
    assign almost_full = (count >= CNT_W'(DEPTH - 1));

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> (count != CNT_W'(DEPTH))
    ) else $error("operand_fifo: push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> (count != '0)
    ) else $error("operand_fifo: pop while empty");

endmodule

//--- src/booth_mul.sv
module booth_mul import fxp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        empty,
    input  mul_pair_t   head,
    output logic        pop,
    output logic        done,
    output mul_result_t res
);

    // Two guard bits cover plus or minus twice the multiplicand
    localparam int SUM_W = DATA_W + 2;
    localparam logic [PROD_W-1:0] ROUND_K = PROD_W'(1) << (FRAC_BITS - 1);

    mul_state_t        state;
    logic [DATA_W-1:0] mcand;
    logic [DATA_W-1:0] acc;
    logic [DATA_W:0]   low;
    logic [2:0]        iter;
    logic [2:0]        iter_next;
    logic              iter_wrap;

    logic [SUM_W-1:0]  mcand_ext;
    logic [SUM_W-1:0]  addend;
    logic [SUM_W-1:0]  sum;
    logic [PROD_W-1:0] rounded;
    logic [PROD_W-1:DATA_W+FRAC_BITS-1] top_bits;

    assign mcand_ext = {{2{mcand[DATA_W-1]}}, mcand};

    // Booth digit from the low three bits
    always_comb begin
        case (low[2:0])
            3'b001, 3'b010: addend = mcand_ext;
            3'b011:         addend = mcand_ext << 1;
            3'b100:         addend = -(mcand_ext << 1);
            3'b101, 3'b110: addend = -mcand_ext;
            default:        addend = '0;
        endcase
    end

    assign sum = {{2{acc[DATA_W-1]}}, acc} + addend;

    assign {iter_wrap, iter_next} = {1'b0, iter} + 4'd1;

    assign pop  = (state != ST_RUN) && !empty;
    assign done = (state == ST_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            iter  <= '0;
        end else begin
            case (state)
                ST_RUN: begin
                    iter <= iter_next;
                    if (iter_wrap) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    // Back-to-back load straight from the done cycle
                    if (pop) begin
                        state <= ST_RUN;
                        iter  <= '0;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            mcand <= head.multiplicand;
            acc   <= '0;
            low   <= {head.multiplier, 1'b0};
        end else if (state == ST_RUN) begin
            // Arithmetic shift right by two
            acc <= sum[SUM_W-1:2];
            low <= {sum[1:0], low[DATA_W:2]};
        end
    end

    // Round half up, then keep the Q8.7 window
    assign rounded  = {acc, low[DATA_W:1]} + ROUND_K;
    assign top_bits = rounded[PROD_W-1:DATA_W+FRAC_BITS-1];

    assign res.product  = rounded[DATA_W+FRAC_BITS-1:FRAC_BITS];
    assign res.overflow = !((&top_bits) || !(|top_bits));

    a_done_single: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    ) else $error("booth_mul: done held for two cycles");

endmodule

//--- src/fxp_mul_top.sv
module fxp_mul_top import fxp_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  op_req_t     req,
    output logic        almost_full,
    output logic        done,
    output mul_result_t res
);

    logic      pair_valid;
    mul_pair_t pair;
    logic      fifo_empty;
    mul_pair_t fifo_pair;
    logic      pop;

    op_decode u_op_decode (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    operand_fifo #(
        .DEPTH (DEPTH)
    ) u_operand_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (pair_valid),
        .push_pair   (pair),
        .pop         (pop),
        .head        (fifo_pair),
        .empty       (fifo_empty),
        .almost_full (almost_full)
    );

    booth_mul u_booth_mul (
        .clk   (clk),
        .rst   (rst),
        .empty (fifo_empty),
        .head  (fifo_pair),
        .pop   (pop),
        .done  (done),
        .res   (res)
    );

endmodule

//--- verif/fxp_mul_tb.sv
module fxp_mul_tb import fxp_pkg::*; ();

    localparam int DEPTH       = 4;
    localparam int CLK_PERIOD  = 8;
    localparam int NUM_REC     = 22;
    localparam int REC_WORDS   = 5;
    localparam int BURST_FIRST = 14;
    localparam int SEED        = 71349;

    logic        clk;
    logic        rst;
    logic        req_valid;
    op_req_t     req;
    logic        almost_full;
    logic        done;
    mul_result_t res;

    // Opcode, a, b, product and overflow per record
    logic [DATA_W-1:0] vec [NUM_REC*REC_WORDS];
    int                gap [NUM_REC];
    mul_result_t       exp_q [$];
    int                sent;
    int                retired;
    int                checked;
    bit                saw_almost_full;

    fxp_mul_top #(
        .DEPTH (DEPTH)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .almost_full (almost_full),
        .done        (done),
        .res         (res)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_product(input int idx, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] want);
        if (got !== want) begin
            stop_with_failure($sformatf("Error at %0t: record %0d product %h, expected %h",
                $time, idx, got, want));
        end
    endtask

    task automatic check_overflow(input int idx, input logic got, input logic want);
        if (got !== want) begin
            stop_with_failure($sformatf("Error at %0t: record %0d overflow %b, expected %b",
                $time, idx, got, want));
        end
    endtask

    task automatic drive_requests();
        int          i;
        int          idle;
        bit          room;
        op_req_t     r;
        mul_result_t want;
        i    = 0;
        idle = gap[0];
        while (i < NUM_REC) begin
            @(negedge clk);
            if (done) begin
                retired++;
            end
            if (almost_full) begin
                saw_almost_full = 1'b1;
            end
            // Sampled almost_full is a cycle old so outstanding requests are capped too
            room = !almost_full && ((sent - retired) < DEPTH);
            @(posedge clk);
            if (room && idle == 0) begin
                r.opcode      = op_t'(vec[i*REC_WORDS][1:0]);
                r.a           = vec[i*REC_WORDS+1];
                r.b           = vec[i*REC_WORDS+2];
                want.product  = vec[i*REC_WORDS+3];
                want.overflow = vec[i*REC_WORDS+4][0];
                req_valid <= 1'b1;
                req       <= r;
                exp_q.push_back(want);
                sent++;
                i++;
                if (i < NUM_REC) begin
                    idle = gap[i];
                end
            end else begin
                req_valid <= 1'b0;
                if (idle > 0) begin
                    idle--;
                end
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // Results in request order
    always @(negedge clk) begin
        mul_result_t want;
        if (!rst && done) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("A done pulse came with no request outstanding");
            end else begin
                want = exp_q.pop_front();
                check_product(checked, res.product, want.product);
                check_overflow(checked, res.overflow, want.overflow);
                checked++;
            end
        end
    end

    initial begin
        int total_gap;
        int limit_cycles;
        clk             = 1'b0;
        rst             = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        sent            = 0;
        retired         = 0;
        checked         = 0;
        saw_almost_full = 1'b0;
        void'($urandom(SEED));
        $readmemh("verif/fxp_mul_testdata.txt", vec);

        total_gap = 0;
        for (int i = 0; i < NUM_REC; i++) begin
            gap[i]     = (i >= BURST_FIRST) ? 0 : int'($urandom_range(12, 0));
            total_gap += gap[i];
        end
        limit_cycles = NUM_REC * 9 + total_gap + 200;

        fork
            begin
                #(limit_cycles * CLK_PERIOD);
                stop_with_failure($sformatf(
                    "Timeout: results stopped arriving, %0d of %0d checked",
                    checked, NUM_REC));
            end
        join_none

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Quiet stretch where done has to stay low
        repeat (5) @(posedge clk);
        drive_requests();

        wait (checked == NUM_REC);
        repeat (20) @(posedge clk);
        if (saw_almost_full) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure("The back-to-back burst never raised almost_full");
        end
    end

endmodule

//--- list.f
src/fxp_pkg.sv
src/op_decode.sv
src/operand_fifo.sv
src/booth_mul.sv
src/fxp_mul_top.sv
verif/fxp_mul_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fxp_mul_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a listed source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/fxp_mul_testdata.txt
// opcode(0 mul, 1 sqr, 2 nmul)  a  b  expected product  expected overflow
// Rows from 14 on are sent back to back
0 0100 0180 0300 0
0 FF00 0180 FD00 0
0 00C0 FF40 FEE0 0
0 0001 0040 0001 0
0 0001 003F 0000 0
0 FFFF 0040 0000 0
0 FFFF 0041 FFFF 0
1 0180 1234 0480 0
1 FE80 BEEF 0480 0
2 0100 0180 FD00 0
2 8000 0080 8000 0
0 8000 0080 8000 0
0 7FFF 7FFF FE00 1
0 8000 7FFF 0100 1
0 7FFF 0080 7FFF 0
0 7FFF 0081 80FF 1
0 8000 0081 7F00 1
1 0B50 0000 FFF2 1
2 FF40 FF40 FEE0 0
0 0003 00C0 0005 0
1 FFFF 5555 0000 0
2 0080 0280 FD80 0
